// ==== hw/awe_pkg.sv ====
`default_nettype none

package awe_pkg;

    ////////////////////////////////////////
    // RAM geometry
    ////////////////////////////////////////

    // Entries per row RAM, two row halves of 128 columns
    localparam int ram_depth  = 256;
    localparam int ram_addr_w = $clog2(ram_depth);

    // Column index below the half-select bit
    localparam int col_w      = ram_addr_w - 1;

    ////////////////////////////////////////
    // Accelerator state
    ////////////////////////////////////////

    // One-hot, same encoding as the layer controller
    typedef enum logic [3:0] {
        st_idle          = 4'b0001,
        st_prime_buffer  = 4'b0010,
        st_wait_pfb_load = 4'b0100,
        st_active        = 4'b1000
    } awe_state_t;

    // State and gray code seen by every engine
    typedef struct packed {
        awe_state_t  state;
        logic [1:0]  gray_code;
    } awe_ctrl_t;

    ////////////////////////////////////////
    // Request words
    ////////////////////////////////////////

    // Read sequence word, flip bit swaps the halves of both RAMs
    typedef struct packed {
        logic             flip;
        logic [col_w-1:0] col_even;
        logic [col_w-1:0] col_odd;
    } seq_word_t;

    // Priming write, rows 0 to 2 carry data
    typedef struct packed {
        logic             valid;
        logic [1:0]       row;
        logic [col_w-1:0] col;
    } prime_wr_t;

    // Incoming row during active processing
    typedef struct packed {
        logic             valid;
        logic [col_w-1:0] col;
    } row_wr_t;

endpackage

`default_nettype wire

// ==== hw/awe_bram.sv ====
`default_nettype none

module awe_bram #(
    parameter int pixel_width = 18
) (
    input  logic                           clk_500MHz,
    input  logic                           wr_en,
    input  logic [awe_pkg::ram_addr_w-1:0] wr_addr,
    input  logic [pixel_width-1:0]         wr_data,
    input  logic                           rd_en,
    input  logic [awe_pkg::ram_addr_w-1:0] rd_addr,
    output logic [pixel_width-1:0]         rd_data
);

    import awe_pkg::*;

    // Storage array, inferred as block RAM
    logic [pixel_width-1:0] mem [ram_depth];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk_500MHz) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Registered read port
    ////////////////////////////////////////

    // Same-address collision returns the old word
    always_ff @(posedge clk_500MHz) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/awe_engine_rows.sv ====
`default_nettype none

module awe_engine_rows #(
    parameter int pixel_width = 18
) (
    input  logic                        clk_500MHz,
    input  logic                        accel_rst,
    input  awe_pkg::awe_ctrl_t          ctrl,
    input  awe_pkg::prime_wr_t          prime_wr,
    input  awe_pkg::row_wr_t            row_wr,
    input  logic [awe_pkg::col_w-1:0]   num_input_cols,
    input  awe_pkg::seq_word_t          seq_word,
    input  logic [pixel_width-1:0]      pixel_in,
    input  logic                        start,
    output logic [2*pixel_width-1:0]    pixel_pair,
    output logic                        dataout_valid
);

    import awe_pkg::*;

    // Next-cycle write request
    logic                   even_wr_en_nxt;
    logic                   odd_wr_en_nxt;
    logic [ram_addr_w-1:0]  wr_addr_nxt;

    // Registered write request, one location shared by both RAMs
    logic                   even_wr_en;
    logic                   odd_wr_en;
    logic [ram_addr_w-1:0]  wr_addr;
    logic [pixel_width-1:0] wr_data;

    // Read request
    logic                   rd_req;
    logic [ram_addr_w-1:0]  even_rd_addr_nxt;
    logic [ram_addr_w-1:0]  odd_rd_addr_nxt;
    logic                   rd_en;
    logic                   rd_en_d;
    logic [ram_addr_w-1:0]  even_rd_addr;
    logic [ram_addr_w-1:0]  odd_rd_addr;

    // RAM outputs
    logic [pixel_width-1:0] even_rd_data;
    logic [pixel_width-1:0] odd_rd_data;

    ////////////////////////////////////////
    // Write steering
    ////////////////////////////////////////

    always_comb begin
        even_wr_en_nxt = 1'b0;
        odd_wr_en_nxt  = 1'b0;
        wr_addr_nxt    = {1'b0, prime_wr.col};
        case (ctrl.state)
            st_prime_buffer: begin
                // Columns past the row width are dropped
                if (prime_wr.valid && (prime_wr.col <= num_input_cols)) begin
                    case (prime_wr.row)
                        2'd0: begin
                            even_wr_en_nxt = 1'b1;
                            odd_wr_en_nxt  = 1'b1;
                            wr_addr_nxt    = {1'b0, prime_wr.col};
                        end
                        2'd1: begin
                            odd_wr_en_nxt  = 1'b1;
                            wr_addr_nxt    = {1'b1, prime_wr.col};
                        end
                        2'd2: begin
                            even_wr_en_nxt = 1'b1;
                            wr_addr_nxt    = {1'b1, prime_wr.col};
                        end
                        default: begin
                            even_wr_en_nxt = 1'b0;
                            odd_wr_en_nxt  = 1'b0;
                        end
                    endcase
                end
            end
            st_active: begin
                if (row_wr.valid) begin
                    // Equal gray bits mean the new row goes to the odd RAM
                    if (ctrl.gray_code[0] == ctrl.gray_code[1]) begin
                        odd_wr_en_nxt  = 1'b1;
                    end else begin
                        even_wr_en_nxt = 1'b1;
                    end
                    wr_addr_nxt = {ctrl.gray_code[0], row_wr.col};
                end
            end
            default: begin
                even_wr_en_nxt = 1'b0;
                odd_wr_en_nxt  = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // Read address decode
    ////////////////////////////////////////

    assign rd_req           = (ctrl.state == st_active) && start;
    assign even_rd_addr_nxt = {ctrl.gray_code[0] ^ seq_word.flip, seq_word.col_even};
    assign odd_rd_addr_nxt  = {ctrl.gray_code[1] ^ seq_word.flip, seq_word.col_odd};

    ////////////////////////////////////////
    // Request and output registers
    ////////////////////////////////////////

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            even_wr_en    <= 1'b0;
            odd_wr_en     <= 1'b0;
            rd_en         <= 1'b0;
            rd_en_d       <= 1'b0;
            dataout_valid <= 1'b0;
        end else begin
            even_wr_en    <= even_wr_en_nxt;
            odd_wr_en     <= odd_wr_en_nxt;
            rd_en         <= rd_req;
            // RAM data is ready one cycle after rd_en
            rd_en_d       <= rd_en;
            dataout_valid <= rd_en_d;
        end
    end

    always_ff @(posedge clk_500MHz) begin
        if (even_wr_en_nxt || odd_wr_en_nxt) begin
            wr_addr <= wr_addr_nxt;
            wr_data <= pixel_in;
        end
        if (rd_req) begin
            even_rd_addr <= even_rd_addr_nxt;
            odd_rd_addr  <= odd_rd_addr_nxt;
        end
        // Pair holds until the next read comes back
        if (rd_en_d) begin
            pixel_pair <= {odd_rd_data, even_rd_data};
        end
    end

    ////////////////////////////////////////
    // Row RAMs
    ////////////////////////////////////////

    awe_bram #(
        .pixel_width (pixel_width)
    ) i_even_ram (
        .clk_500MHz (clk_500MHz),
        .wr_en      (even_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (even_rd_addr),
        .rd_data    (even_rd_data)
    );

    awe_bram #(
        .pixel_width (pixel_width)
    ) i_odd_ram (
        .clk_500MHz (clk_500MHz),
        .wr_en      (odd_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (odd_rd_addr),
        .rd_data    (odd_rd_data)
    );

endmodule

`default_nettype wire

// ==== hw/awe_row_buffer_top.sv ====
`default_nettype none

module awe_row_buffer_top #(
    parameter int pixel_width = 18
) (
    input  logic                        clk_500MHz,
    input  logic                        accel_rst,
    input  awe_pkg::awe_ctrl_t          ctrl,
    input  awe_pkg::prime_wr_t          prime_wr,
    input  awe_pkg::row_wr_t            row_wr,
    input  logic [awe_pkg::col_w-1:0]   num_input_cols,
    input  awe_pkg::seq_word_t          seq_word,
    input  logic [pixel_width-1:0]      pixel_in,
    input  logic [1:0]                  ce_start,
    output logic [4*pixel_width-1:0]    pixel_dataout,
    output logic [1:0]                  dataout_valid
);

    // Odd pixel sits above the even pixel in each pair
    logic [2*pixel_width-1:0] engine0_pair;
    logic [2*pixel_width-1:0] engine1_pair;

    ////////////////////////////////////////
    // Convolution engine 0
    ////////////////////////////////////////

    awe_engine_rows #(
        .pixel_width (pixel_width)
    ) i_engine0_rows (
        .clk_500MHz     (clk_500MHz),
        .accel_rst      (accel_rst),
        .ctrl           (ctrl),
        .prime_wr       (prime_wr),
        .row_wr         (row_wr),
        .num_input_cols (num_input_cols),
        .seq_word       (seq_word),
        .pixel_in       (pixel_in),
        .start          (ce_start[0]),
        .pixel_pair     (engine0_pair),
        .dataout_valid  (dataout_valid[0])
    );

    ////////////////////////////////////////
    // Convolution engine 1
    ////////////////////////////////////////

    // Same pixel stream as engine 0, own start
    awe_engine_rows #(
        .pixel_width (pixel_width)
    ) i_engine1_rows (
        .clk_500MHz     (clk_500MHz),
        .accel_rst      (accel_rst),
        .ctrl           (ctrl),
        .prime_wr       (prime_wr),
        .row_wr         (row_wr),
        .num_input_cols (num_input_cols),
        .seq_word       (seq_word),
        .pixel_in       (pixel_in),
        .start          (ce_start[1]),
        .pixel_pair     (engine1_pair),
        .dataout_valid  (dataout_valid[1])
    );

    ////////////////////////////////////////
    // Output word
    ////////////////////////////////////////

    // Engine 1 in the upper half
    assign pixel_dataout = {engine1_pair, engine0_pair};

endmodule

`default_nettype wire

// ==== include/tb_awe_tasks.svh ====
`ifndef TB_AWE_TASKS_SVH
`define TB_AWE_TASKS_SVH

// Drive point one unit after the rising edge
task automatic next_cycle();
    @(posedge clk_500MHz);
    #1;
endtask

function automatic logic [pixel_width-1:0] random_pixel();
    logic [31:0] r;
    r = $random(seed);
    return r[pixel_width-1:0];
endfunction

task automatic prime_write(input logic [1:0] row, input logic [col_w-1:0] col);
    logic [pixel_width-1:0] pix;
    pix = random_pixel();
    prime_wr.valid = 1'b1;
    prime_wr.row = row;
    prime_wr.col = col;
    pixel_in = pix;
    if (ctrl.state == st_prime_buffer && col <= num_input_cols) begin
        if (row == 2'd0) begin
            model_even[{1'b0, col}] = pix;
            model_odd[{1'b0, col}] = pix;
        end else if (row == 2'd1) begin
            model_odd[{1'b1, col}] = pix;
        end else if (row == 2'd2) begin
            model_even[{1'b1, col}] = pix;
        end
    end
    next_cycle();
    prime_wr.valid = 1'b0;
endtask

// New row goes to the odd RAM when both gray bits agree
task automatic row_write(input logic [col_w-1:0] col);
    logic [pixel_width-1:0] pix;
    pix = random_pixel();
    row_wr.valid = 1'b1;
    row_wr.col = col;
    pixel_in = pix;
    if (ctrl.state == st_active) begin
        if (ctrl.gray_code[0] == ctrl.gray_code[1])
            model_odd[{ctrl.gray_code[0], col}] = pix;
        else
            model_even[{ctrl.gray_code[0], col}] = pix;
    end
    next_cycle();
    row_wr.valid = 1'b0;
endtask

task automatic issue_read(input logic [1:0] start, input logic flip,
                          input logic [col_w-1:0] col_even, input logic [col_w-1:0] col_odd);
    expect_t want;
    want.cycle = cycle + latency + 1;
    want.pair = {model_odd[{ctrl.gray_code[1] ^ flip, col_odd}],
                 model_even[{ctrl.gray_code[0] ^ flip, col_even}]};
    seq_word.flip = flip;
    seq_word.col_even = col_even;
    seq_word.col_odd = col_odd;
    ce_start = start;
    if (ctrl.state == st_active) begin
        if (start[0])
            exp_q0.push_back(want);
        if (start[1])
            exp_q1.push_back(want);
    end
    next_cycle();
    ce_start = 2'b00;
endtask

task automatic check_output(input logic e);
    expect_t want;
    logic [2*pixel_width-1:0] got;
    got = (e == 1'b0) ? pixel_dataout[2*pixel_width-1:0]
                      : pixel_dataout[4*pixel_width-1:2*pixel_width];
    if (dataout_valid[e] !== 1'b1) begin
        // Pair must hold between valid outputs
        if (have_pair[e] && got !== last_pair[e]) begin
            $display("MISMATCH at %0t: engine %0d output %h changed without valid, held %h",
                     $time, e, got, last_pair[e]);
            mismatch_count++;
        end
    end else if ((e == 1'b0 && exp_q0.size() == 0) || (e == 1'b1 && exp_q1.size() == 0)) begin
        $display("ERROR at %0t: engine %0d raised dataout_valid with no read pending", $time, e);
        error_count++;
    end else begin
        if (e == 1'b0)
            want = exp_q0.pop_front();
        else
            want = exp_q1.pop_front();
        if (want.cycle != cycle) begin
            $display("MISMATCH at %0t: engine %0d valid in cycle %0d, expected cycle %0d",
                     $time, e, cycle, want.cycle);
            mismatch_count++;
        end
        if (got !== want.pair) begin
            $display("MISMATCH at %0t: engine %0d pair %h, expected %h", $time, e, got, want.pair);
            mismatch_count++;
        end
        last_pair[e] = got;
        have_pair[e] = 1'b1;
    end
endtask

task automatic wait_outputs();
    int waited;
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < drain_limit) begin
        next_cycle();
        waited++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
        $display("ERROR at %0t: %0d read results never came back with valid",
                 $time, exp_q0.size() + exp_q1.size());
        error_count++;
        exp_q0.delete();
        exp_q1.delete();
    end
    repeat (2) next_cycle();
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic quiet_after_reset();
    repeat (10) begin
        if (dataout_valid !== 2'b00) begin
            $display("MISMATCH at %0t: dataout_valid %b after reset, expected 00",
                     $time, dataout_valid);
            mismatch_count++;
        end
        next_cycle();
    end
endtask

task automatic priming_readback();
    int row;
    int col;
    int f;
    ctrl.state = st_prime_buffer;
    // First pass gives columns 21 to 25 their earlier contents
    num_input_cols = 7'd25;
    for (row = 0; row < 3; row++)
        for (col = 0; col <= 25; col++)
            prime_write(row[1:0], col[col_w-1:0]);
    num_input_cols = 7'd20;
    for (row = 0; row < 3; row++)
        for (col = 0; col <= 25; col++)
            prime_write(row[1:0], col[col_w-1:0]);
    prime_write(2'd3, 7'd5);
    ctrl.state = st_active;
    ctrl.gray_code = 2'b00;
    for (f = 0; f < 2; f++)
        for (col = 0; col <= 25; col++)
            issue_read(2'b11, f[0], col[col_w-1:0], col[col_w-1:0]);
    wait_outputs();
endtask

// Consecutive requests with each arrival cycle checked by the monitor
task automatic pipelined_reads();
    int i;
    int ce;
    int co;
    for (i = 0; i < 8; i++) begin
        ce = i * 3;
        co = 25 - i * 2;
        issue_read(2'b11, i[0], ce[col_w-1:0], co[col_w-1:0]);
    end
    wait_outputs();
endtask

task automatic engine_independence();
    logic [2*pixel_width-1:0] lower;
    // Engine 0 pair from the first read, kept through the engine 1 read
    lower = {model_odd[{ctrl.gray_code[1], 7'd9}], model_even[{ctrl.gray_code[0], 7'd4}]};
    issue_read(2'b01, 1'b0, 7'd4, 7'd9);
    wait_outputs();
    issue_read(2'b10, 1'b1, 7'd11, 7'd2);
    wait_outputs();
    if (pixel_dataout[2*pixel_width-1:0] !== lower) begin
        $display("MISMATCH at %0t: engine 0 half %h changed, expected %h",
                 $time, pixel_dataout[2*pixel_width-1:0], lower);
        mismatch_count++;
    end
endtask

task automatic gray_flip_reads();
    int g;
    int f;
    int col;
    int co;
    for (g = 0; g < 4; g++) begin
        ctrl.gray_code = g[1:0];
        for (col = 0; col < 8; col++)
            row_write(col[col_w-1:0]);
    end
    for (g = 0; g < 4; g++) begin
        ctrl.gray_code = g[1:0];
        for (f = 0; f < 2; f++)
            for (col = 0; col < 8; col++) begin
                co = (col + 3) % 8;
                issue_read(2'b11, f[0], col[col_w-1:0], co[col_w-1:0]);
            end
    end
    wait_outputs();
endtask

// Writes and reads outside the two working states are dropped
task automatic inactive_states();
    int col;
    ctrl.gray_code = 2'b00;
    ctrl.state = st_idle;
    for (col = 0; col < 4; col++)
        prime_write(2'd0, col[col_w-1:0]);
    issue_read(2'b11, 1'b0, 7'd0, 7'd0);
    ctrl.state = st_wait_pfb_load;
    for (col = 0; col < 4; col++)
        prime_write(2'd2, col[col_w-1:0]);
    row_write(7'd1);
    issue_read(2'b11, 1'b1, 7'd1, 7'd1);
    repeat (6) next_cycle();
    ctrl.state = st_active;
    for (col = 0; col < 4; col++) begin
        issue_read(2'b11, 1'b0, col[col_w-1:0], col[col_w-1:0]);
        issue_read(2'b11, 1'b1, col[col_w-1:0], col[col_w-1:0]);
    end
    wait_outputs();
endtask

`endif

// ==== testbench/tb_awe_row_buffer.sv ====
`default_nettype none

module tb_awe_row_buffer;

    import awe_pkg::*;

    localparam int pixel_width = 18;
    localparam int clk_period  = 8;
    localparam int latency     = 2;
    localparam int drain_limit = 16;

    // Rough cycle count of each test including drains
    localparam int drain_cycles    = drain_limit + 2;
    localparam int reset_cycles    = 8 + 10;
    localparam int priming_cycles  = 2 * 3 * 26 + 1 + 2 * 26 + drain_cycles;
    localparam int pipe_cycles     = 8 + drain_cycles;
    localparam int indep_cycles    = 2 * (1 + drain_cycles);
    localparam int gray_cycles     = 4 * 8 + 4 * 2 * 8 + drain_cycles;
    localparam int inactive_cycles = 2 * 6 + 6 + 8 + drain_cycles;
    localparam int total_cycles    = reset_cycles + priming_cycles + pipe_cycles
                                     + indep_cycles + gray_cycles + inactive_cycles;
    localparam int watchdog_time   = total_cycles * 2 * clk_period;

    // One pending read result and the cycle it must show up in
    typedef struct packed {
        logic [31:0]              cycle;
        logic [2*pixel_width-1:0] pair;
    } expect_t;

    logic                     clk_500MHz;
    logic                     accel_rst;
    awe_ctrl_t                ctrl;
    prime_wr_t                prime_wr;
    row_wr_t                  row_wr;
    logic [col_w-1:0]         num_input_cols;
    seq_word_t                seq_word;
    logic [pixel_width-1:0]   pixel_in;
    logic [1:0]               ce_start;
    logic [4*pixel_width-1:0] pixel_dataout;
    logic [1:0]               dataout_valid;

    // Expected RAM contents shared by both engines
    logic [pixel_width-1:0]   model_even [ram_depth];
    logic [pixel_width-1:0]   model_odd  [ram_depth];

    expect_t                  exp_q0 [$];
    expect_t                  exp_q1 [$];
    logic [2*pixel_width-1:0] last_pair [2];
    logic [1:0]               have_pair;

    int     cycle = 0;
    integer seed;
    int     mismatch_count = 0;
    int     error_count = 0;

    `include "tb_awe_tasks.svh"

    ////////////////////////////////////////
    // Clock and DUT
    ////////////////////////////////////////

    initial begin
        clk_500MHz = 1'b0;
        forever #(clk_period / 2) clk_500MHz = ~clk_500MHz;
    end

    always @(posedge clk_500MHz) cycle <= cycle + 1;

    awe_row_buffer_top #(
        .pixel_width (pixel_width)
    ) i_awe_row_buffer_top (
        .clk_500MHz     (clk_500MHz),
        .accel_rst      (accel_rst),
        .ctrl           (ctrl),
        .prime_wr       (prime_wr),
        .row_wr         (row_wr),
        .num_input_cols (num_input_cols),
        .seq_word       (seq_word),
        .pixel_in       (pixel_in),
        .ce_start       (ce_start),
        .pixel_dataout  (pixel_dataout),
        .dataout_valid  (dataout_valid)
    );

    ////////////////////////////////////////
    // Output monitor and watchdog
    ////////////////////////////////////////

    // Outputs are stable at the falling edge
    initial begin
        have_pair = 2'b00;
        forever begin
            @(negedge clk_500MHz);
            if (!accel_rst) begin
                check_output(1'b0);
                check_output(1'b1);
            end
        end
    end

    initial begin
        #(watchdog_time);
        $display("ERROR: watchdog expired at %0t, the test sequence never finished", $time);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        seed = 21002;
        accel_rst = 1'b1;
        ctrl.state = st_idle;
        ctrl.gray_code = 2'b00;
        prime_wr = '0;
        row_wr = '0;
        num_input_cols = '0;
        seq_word = '0;
        pixel_in = '0;
        ce_start = 2'b00;
        repeat (8) @(posedge clk_500MHz);
        #1;
        accel_rst = 1'b0;

        quiet_after_reset();
        priming_readback();
        pipelined_reads();
        engine_independence();
        gray_flip_reads();
        inactive_states();

        $display("Run done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hw/awe_pkg.sv
hw/awe_bram.sv
hw/awe_engine_rows.sv
hw/awe_row_buffer_top.sv
testbench/tb_awe_row_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the row buffer testbench with Verilator
set -u
cd "$(dirname "$0")"

log=sim.log
build=obj_dir

verilator --binary --timing -j 0 -f project.f \
    --top-module tb_awe_row_buffer --Mdir "$build" -o tb_awe_row_buffer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build/tb_awe_row_buffer" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$log"; then
    exit 1
fi
exit 0
